/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_enc_fixture
FILELIST ?= enc_fixture.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal
PASS_MSG ?= Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* enc_fixture.f */
+incdir+verification
verilog/enc_pkg.sv
verilog/enc_emulator.sv
verilog/quad_decoder.sv
verilog/position_counter.sv
verilog/homing_ctrl.sv
verilog/enc_fixture_top.sv
verification/tb_enc_fixture.sv

/* verification/tb_enc_tasks.svh */
`ifndef TB_ENC_TASKS_SVH
`define TB_ENC_TASKS_SVH

// ****************************************
// checks and model
// ****************************************

task automatic compare_value(input string name, input logic [31:0] got,
	input logic [31:0] exp);
	if (got !== exp)
	begin
		$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		$display("Something failed");
		$fatal(1);
	end
endtask

// a leads b in the (a,b) pattern of each phase when turning forward.
function automatic logic [1:0] quad_pattern(input int phase);
	case (phase)
		0: return 2'b00;
		1: return 2'b10;
		2: return 2'b11;
		default: return 2'b01;
	endcase
endfunction

function automatic logic index_window(input int edge_pos);
	return (edge_pos >= enc_pkg::INDEX_FIRST) && (edge_pos <= enc_pkg::INDEX_LAST);
endfunction

task automatic step_model(input int delta);
	exp_pos = exp_pos + delta;
	exp_phase = (exp_phase + delta + 4) % 4;
	exp_edge = (exp_edge + delta + enc_pkg::COUNTS_PER_REV) % enc_pkg::COUNTS_PER_REV;
endtask

task automatic check_emulator();
	compare_value("emu_out.ab", {emu_out.a, emu_out.b}, quad_pattern(exp_phase));
	compare_value("emu_out.index", emu_out.index, index_window(exp_edge));
	compare_value("home", home, index_window(exp_edge));
endtask

task automatic check_status(input logic err_exp);
	compare_value("status.position", $unsigned(status.position),
		exp_pos[enc_pkg::POS_W-1:0]);
	compare_value("status.err", status.err, err_exp);
endtask

task automatic wait_settle();
	repeat (SETTLE) @(posedge out_200hz);
	@(negedge out_200hz);
endtask

// ****************************************
// stimulus
// ****************************************

// the emulator pins move two clocks after the jog pulse.
task automatic jog_once(input logic fwd);
	@(posedge out_200hz);
	jog_fwd <= fwd;
	jog_rev <= !fwd;
	@(posedge out_200hz);
	jog_fwd <= 1'b0;
	jog_rev <= 1'b0;
	@(posedge out_200hz);
	@(negedge out_200hz);
	step_model(fwd ? 1 : -1);
	check_emulator();
endtask

task automatic jog_run(input logic fwd, input int count);
	repeat (count) jog_once(fwd);
	wait_settle();
	check_status(1'b0);
endtask

task automatic pulse_home();
	@(posedge out_200hz);
	cmd_home <= 1'b1;
	@(posedge out_200hz);
	cmd_home <= 1'b0;
endtask

// ****************************************
// directed tests
// ****************************************

task automatic run_reset_values();
	check_status(1'b0);
	compare_value("status.index_pos", $unsigned(status.index_pos), 0);
	compare_value("homed", homed, 0);
	compare_value("led", led, 0);
	compare_value("emu_out", emu_out, 0);
	compare_value("home", home, 0);
endtask

task automatic forward_jog_count();
	int n;
	n = 5 + ($unsigned($random(seed)) % 36);
	jog_run(1'b1, n);
endtask

task automatic reverse_jog_wrap();
	int n;
	n = exp_pos + 3 + ($unsigned($random(seed)) % 8);
	jog_run(1'b0, n);
endtask

task automatic home_and_zero();
	int start_pos;
	int start_phase;
	int moves_before;
	int moves;
	int n;
	logic prev_led;
	// park at edge zero so the seek starts well before the home window.
	while (exp_edge != 0)
	begin
		jog_once(1'b1);
	end
	wait_settle();
	check_status(1'b0);
	start_pos = exp_pos;
	start_phase = exp_phase;
	moves_before = ab_moves;
	pulse_home();
	@(negedge out_200hz);
	compare_value("led", led, 1);
	prev_led = led;
	while (!homed)
	begin
		@(negedge out_200hz);
		if (!homed)
		begin
			compare_value("led", led, !prev_led);
			prev_led = led;
		end
	end
	compare_value("led", led, 1);
	wait_settle();
	// the step onto the first index edge is the zero point.
	moves = ab_moves - moves_before;
	exp_pos = moves - enc_pkg::INDEX_FIRST;
	exp_edge = moves % enc_pkg::COUNTS_PER_REV;
	exp_phase = (start_phase + moves) % 4;
	check_emulator();
	check_status(1'b0);
	n = start_pos + enc_pkg::INDEX_FIRST - 1;
	compare_value("status.index_pos", $unsigned(status.index_pos),
		n[enc_pkg::POS_W-1:0]);
	n = 3 + ($unsigned($random(seed)) % 20);
	jog_run(1'b1, n);
	compare_value("homed", homed, 1);
	compare_value("led", led, 1);
endtask

task automatic illegal_step_error();
	enc_pkg::quad_t v;
	logic [1:0] ab;
	ab = quad_pattern(exp_phase);
	v.a = ab[1];
	v.b = ab[0];
	v.index = index_window(exp_edge);
	@(posedge out_200hz);
	inj_val <= v;
	inject <= 1'b1;
	wait_settle();
	check_status(1'b0);
	// both phases flip in one sample.
	v.a = !v.a;
	v.b = !v.b;
	@(posedge out_200hz);
	inj_val <= v;
	wait_settle();
	check_status(1'b1);
	pulse_home();
	wait_settle();
	check_status(1'b0);
endtask

`endif

/* verification/tb_enc_fixture.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_enc_fixture;

	// ****************************************
	// run length and timeout
	// ****************************************

	localparam int SETTLE = 8;
	localparam int JOG_CYCLES = 4;
	localparam int MAX_JOGS = 50;
	localparam int HOME_CYCLES = 2 * enc_pkg::COUNTS_PER_REV + 4 * SETTLE;
	localparam int TEST_CYCLES = 16 + SETTLE
		+ MAX_JOGS * JOG_CYCLES + SETTLE
		+ MAX_JOGS * JOG_CYCLES + SETTLE
		+ enc_pkg::COUNTS_PER_REV * JOG_CYCLES + HOME_CYCLES
		+ MAX_JOGS * JOG_CYCLES + 2 * SETTLE
		+ 4 * SETTLE + 8;
	localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;

	logic out_200hz;
	logic rst_n;
	logic jog_fwd;
	logic jog_rev;
	logic cmd_home;
	logic inject;
	enc_pkg::quad_t inj_val;
	enc_pkg::quad_t enc_in;
	enc_pkg::quad_t emu_out;
	logic home;
	enc_pkg::pos_status_t status;
	logic homed;
	logic led;

	// reference model of the emulator and the receive path.
	int exp_pos;
	int exp_edge;
	int exp_phase;

	int ab_moves = 0;
	enc_pkg::quad_t last_emu = '0;
	int cycle_cnt = 0;
	int seed;

	initial
	begin
		out_200hz = 1'b0;
	end

	always #4 out_200hz = ~out_200hz;

	// the receive pins see either the emulator or values set by the test.
	assign enc_in = inject ? inj_val : emu_out;

	enc_fixture_top i_dut (
		.out_200hz (out_200hz),
		.rst_n     (rst_n),
		.jog_fwd   (jog_fwd),
		.jog_rev   (jog_rev),
		.cmd_home  (cmd_home),
		.enc_in    (enc_in),
		.home_in   (home),
		.emu_out   (emu_out),
		.home      (home),
		.status    (status),
		.homed     (homed),
		.led       (led)
	);

	// the homing test reads this count of emulator phase changes.
	always @(posedge out_200hz)
	begin
		if ({emu_out.a, emu_out.b} != {last_emu.a, last_emu.b})
		begin
			ab_moves <= ab_moves + 1;
		end
		last_emu <= emu_out;
	end

	always @(posedge out_200hz)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("Something failed");
			$fatal(1, "timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		end
	end

	`include "tb_enc_tasks.svh"

	// ****************************************
	// test sequence
	// ****************************************

	initial
	begin
		seed = 6712;
		rst_n = 1'b0;
		jog_fwd = 1'b0;
		jog_rev = 1'b0;
		cmd_home = 1'b0;
		inject = 1'b0;
		inj_val = '0;
		exp_pos = 0;
		exp_edge = 0;
		exp_phase = 0;
		repeat (16) @(posedge out_200hz);
		rst_n <= 1'b1;
		@(negedge out_200hz);
		run_reset_values();
		forward_jog_count();
		reverse_jog_wrap();
		home_and_zero();
		illegal_step_error();
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/enc_emulator.sv */
`timescale 1ns/100ps
`default_nettype none

module enc_emulator (
	input wire out_200hz,
	input wire rst_n,
	input wire step,
	input wire dir,
	output enc_pkg::quad_t emu_out,
	output logic home
);

	// phase 0..3 maps to (a,b) = 00, 10, 11, 01 in forward order.
	logic [1:0] phase;
	logic [1:0] phase_nxt;
	enc_pkg::edge_cnt_t edge_cnt;
	enc_pkg::edge_cnt_t edge_nxt;
	logic in_window;

	// ****************************************
	// next phase and edge position
	// ****************************************

	always_comb
	begin
		if (dir)
		begin
			phase_nxt = phase + 2'd1;
			if (edge_cnt == enc_pkg::edge_cnt_t'(enc_pkg::COUNTS_PER_REV - 1))
			begin
				edge_nxt = '0;
			end
			else
			begin
				edge_nxt = edge_cnt + 1'b1;
			end
		end
		else
		begin
			phase_nxt = phase - 2'd1;
			if (edge_cnt == '0)
			begin
				edge_nxt = enc_pkg::edge_cnt_t'(enc_pkg::COUNTS_PER_REV - 1);
			end
			else
			begin
				edge_nxt = edge_cnt - 1'b1;
			end
		end
	end

	assign in_window = (edge_nxt >= enc_pkg::edge_cnt_t'(enc_pkg::INDEX_FIRST)) &&
		(edge_nxt <= enc_pkg::edge_cnt_t'(enc_pkg::INDEX_LAST));

	// ****************************************
	// output registers
	// ****************************************

	// the pins are registered from the next state so phase and index move together.
	always_ff @(posedge out_200hz or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase <= 2'd0;
			edge_cnt <= '0;
			emu_out <= '0;
			home <= 1'b0;
		end
		else if (step)
		begin
			phase <= phase_nxt;
			edge_cnt <= edge_nxt;
			emu_out.a <= phase_nxt[1] ^ phase_nxt[0];
			emu_out.b <= phase_nxt[1];
			emu_out.index <= in_window;
			home <= in_window;
		end
	end

endmodule

`default_nettype wire

/* verilog/enc_fixture_top.sv */
`timescale 1ns/100ps
`default_nettype none

module enc_fixture_top (
	input wire out_200hz,
	input wire rst_n,
	input wire jog_fwd,
	input wire jog_rev,
	input wire cmd_home,
	input wire enc_pkg::quad_t enc_in,
	input wire home_in,
	output enc_pkg::quad_t emu_out,
	output logic home,
	output enc_pkg::pos_status_t status,
	output logic homed,
	output logic led
);

	logic step;
	logic dir;
	enc_pkg::count_evt_t evt;
	logic index_rise;
	logic home_sync;
	logic arm_zero;
	logic clear_err;
	logic index_seen;

	// ****************************************
	// transmit side
	// ****************************************

	enc_emulator i_emulator (
		.out_200hz (out_200hz),
		.rst_n     (rst_n),
		.step      (step),
		.dir       (dir),
		.emu_out   (emu_out),
		.home      (home)
	);

	homing_ctrl i_ctrl (
		.out_200hz  (out_200hz),
		.rst_n      (rst_n),
		.jog_fwd    (jog_fwd),
		.jog_rev    (jog_rev),
		.cmd_home   (cmd_home),
		.home_sync  (home_sync),
		.index_seen (index_seen),
		.step       (step),
		.dir        (dir),
		.arm_zero   (arm_zero),
		.clear_err  (clear_err),
		.homed      (homed),
		.led        (led)
	);

	// ****************************************
	// receive side
	// ****************************************

	quad_decoder i_decoder (
		.out_200hz  (out_200hz),
		.rst_n      (rst_n),
		.enc_in     (enc_in),
		.home_in    (home_in),
		.evt        (evt),
		.index_rise (index_rise),
		.home_sync  (home_sync)
	);

	position_counter i_counter (
		.out_200hz  (out_200hz),
		.rst_n      (rst_n),
		.evt        (evt),
		.index_rise (index_rise),
		.arm_zero   (arm_zero),
		.clear_err  (clear_err),
		.status     (status),
		.index_seen (index_seen)
	);

endmodule

`default_nettype wire

/* verilog/enc_pkg.sv */
`default_nettype none

package enc_pkg;

	// ****************************************
	// revolution geometry
	// ****************************************

	// edges per revolution of the emulated encoder.
	localparam int COUNTS_PER_REV = 26;

	// home and index are high while the edge counter sits in this window.
	localparam int INDEX_FIRST = 23;
	localparam int INDEX_LAST = 24;

	localparam int EDGE_W = $clog2(COUNTS_PER_REV);

	// position counter width, two's complement.
	localparam int POS_W = 16;

	typedef logic [EDGE_W-1:0] edge_cnt_t;

	// ****************************************
	// shared types
	// ****************************************

	typedef struct packed {
		logic a;
		logic b;
		logic index;
	} quad_t;

	// one-cycle pulses out of the decoder.
	typedef struct packed {
		logic up;
		logic down;
		logic err;
	} count_evt_t;

	typedef struct packed {
		logic signed [POS_W-1:0] position;
		logic signed [POS_W-1:0] index_pos;
		logic err;
	} pos_status_t;

	typedef enum logic [1:0] {
		IDLE,
		SEEK_HOME,
		ARM_INDEX,
		HOMED
	} ctrl_state_t;

endpackage

`default_nettype wire

/* verilog/homing_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module homing_ctrl (
	input wire out_200hz,
	input wire rst_n,
	input wire jog_fwd,
	input wire jog_rev,
	input wire cmd_home,
	input wire home_sync,
	input wire index_seen,
	output logic step,
	output logic dir,
	output logic arm_zero,
	output logic clear_err,
	output logic homed,
	output logic led
);

	enc_pkg::ctrl_state_t state;
	enc_pkg::ctrl_state_t state_nxt;
	logic step_nxt;
	logic dir_nxt;
	logic clear_nxt;

	// ****************************************
	// next state
	// ****************************************

	always_comb
	begin
		state_nxt = state;
		step_nxt = 1'b0;
		dir_nxt = dir;
		clear_nxt = 1'b0;
		case (state)
			enc_pkg::IDLE, enc_pkg::HOMED:
			begin
				if (jog_fwd)
				begin
					step_nxt = 1'b1;
					dir_nxt = 1'b1;
				end
				else if (jog_rev)
				begin
					step_nxt = 1'b1;
					dir_nxt = 1'b0;
				end
			end
			enc_pkg::SEEK_HOME:
			begin
				if (home_sync)
				begin
					state_nxt = enc_pkg::ARM_INDEX;
				end
				else
				begin
					step_nxt = 1'b1;
					dir_nxt = 1'b1;
				end
			end
			// keep turning so an encoder parked on home still meets the next index.
			enc_pkg::ARM_INDEX:
			begin
				if (index_seen)
				begin
					state_nxt = enc_pkg::HOMED;
				end
				else
				begin
					step_nxt = 1'b1;
					dir_nxt = 1'b1;
				end
			end
			default:
			begin
				state_nxt = enc_pkg::IDLE;
			end
		endcase
		// a home command restarts the sequence from any state.
		if (cmd_home)
		begin
			state_nxt = enc_pkg::SEEK_HOME;
			step_nxt = 1'b0;
			clear_nxt = 1'b1;
		end
	end

	always_ff @(posedge out_200hz or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= enc_pkg::IDLE;
			step <= 1'b0;
			dir <= 1'b0;
			clear_err <= 1'b0;
			led <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			step <= step_nxt;
			dir <= dir_nxt;
			clear_err <= clear_nxt;
			case (state_nxt)
				enc_pkg::SEEK_HOME, enc_pkg::ARM_INDEX: led <= ~led;
				enc_pkg::HOMED: led <= 1'b1;
				default: led <= 1'b0;
			endcase
		end
	end

	assign arm_zero = (state == enc_pkg::ARM_INDEX);
	assign homed = (state == enc_pkg::HOMED);

endmodule

`default_nettype wire

/* verilog/position_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module position_counter (
	input wire out_200hz,
	input wire rst_n,
	input wire enc_pkg::count_evt_t evt,
	input wire index_rise,
	input wire arm_zero,
	input wire clear_err,
	output enc_pkg::pos_status_t status,
	output logic index_seen
);

	logic signed [enc_pkg::POS_W-1:0] pos_nxt;

	// ****************************************
	// position update
	// ****************************************

	// an armed index replaces the count of that cycle with zero.
	always_comb
	begin
		if (index_rise && arm_zero)
		begin
			pos_nxt = '0;
		end
		else if (evt.up)
		begin
			pos_nxt = status.position + 1'b1;
		end
		else if (evt.down)
		begin
			pos_nxt = status.position - 1'b1;
		end
		else
		begin
			pos_nxt = status.position;
		end
	end

	always_ff @(posedge out_200hz or negedge rst_n)
	begin
		if (!rst_n)
		begin
			status <= '0;
			index_seen <= 1'b0;
		end
		else
		begin
			status.position <= pos_nxt;
			index_seen <= index_rise;
			if (index_rise)
			begin
				status.index_pos <= status.position;
			end
			// a new error in the same cycle wins over the clear.
			if (evt.err)
			begin
				status.err <= 1'b1;
			end
			else if (clear_err)
			begin
				status.err <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/quad_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module quad_decoder (
	input wire out_200hz,
	input wire rst_n,
	input wire enc_pkg::quad_t enc_in,
	input wire home_in,
	output enc_pkg::count_evt_t evt,
	output logic index_rise,
	output logic home_sync
);

	enc_pkg::quad_t sync1;
	enc_pkg::quad_t sync2;
	enc_pkg::quad_t cur;
	enc_pkg::quad_t last;
	logic home_s1;
	logic home_s2;
	logic [1:0] g_cur;
	logic [1:0] g_last;
	logic [1:0] g_diff;

	// ****************************************
	// synchronizer and history
	// ****************************************

	always_ff @(posedge out_200hz or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync1 <= '0;
			sync2 <= '0;
			cur <= '0;
			last <= '0;
			home_s1 <= 1'b0;
			home_s2 <= 1'b0;
		end
		else
		begin
			sync1 <= enc_in;
			sync2 <= sync1;
			cur <= sync2;
			last <= cur;
			home_s1 <= home_in;
			home_s2 <= home_s1;
		end
	end

	assign home_sync = home_s2;

	// gray position of the (a,b) pair, 0..3 in forward order.
	assign g_cur = {cur.b, cur.a ^ cur.b};
	assign g_last = {last.b, last.a ^ last.b};
	assign g_diff = g_cur - g_last;

	// ****************************************
	// transition decode
	// ****************************************

	// a distance of two means both phases moved at once, which is illegal.
	always_ff @(posedge out_200hz or negedge rst_n)
	begin
		if (!rst_n)
		begin
			evt <= '0;
			index_rise <= 1'b0;
		end
		else
		begin
			evt.up <= (g_diff == 2'd1);
			evt.down <= (g_diff == 2'd3);
			evt.err <= (g_diff == 2'd2);
			index_rise <= cur.index & ~last.index;
		end
	end

endmodule

`default_nettype wire
